//--- design/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  localparam int BYTES_PER_WORD = 4;

  // one enable per byte lane
  typedef logic [BYTES_PER_WORD-1:0] byte_mask_t;

  // byte position inside a word
  typedef logic [$clog2(BYTES_PER_WORD)-1:0] byte_off_t;

  // default sizes for the store unit
  localparam int DEF_ROB_TAG_W = 3;
  localparam int DEF_RS_ENTRIES = 8;
  localparam int DEF_CDB_PORTS = 3;

endpackage

`default_nettype wire

//--- design/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // architectural word size
  localparam int XLEN = 32;

  // data and address words share one type
  typedef logic [XLEN-1:0] word_t;

  // funct3 of the S-type store instructions
  typedef enum logic [2:0] {
    sb = 3'd0,
    sh = 3'd1,
    sw = 3'd2
  } store_funct3_e;

endpackage

`default_nettype wire

//--- design/store_issue_port.sv
`timescale 1ns/10ps
`default_nettype none

module store_issue_port #(
  parameter int ROB_TAG_W = 3,
  parameter int CDB_PORTS = 3
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       flush,

  input  logic                       issue_req,
  output logic                       issue_ack,
  input  rv_isa_pkg::store_funct3_e  issue_funct3,
  input  rv_isa_pkg::word_t          issue_imm,
  input  logic [ROB_TAG_W-1:0]       issue_rob_tag,

  input  logic                       rs1_regfile_ready,
  input  rv_isa_pkg::word_t          rs1_regfile_v,
  input  logic [ROB_TAG_W-1:0]       rs1_regfile_tag,
  input  logic                       rs1_rob_ready,
  input  rv_isa_pkg::word_t          rs1_rob_v,
  input  logic                       rs2_regfile_ready,
  input  rv_isa_pkg::word_t          rs2_regfile_v,
  input  logic [ROB_TAG_W-1:0]       rs2_regfile_tag,
  input  logic                       rs2_rob_ready,
  input  rv_isa_pkg::word_t          rs2_rob_v,

  input  logic                       cdb_valid [CDB_PORTS],
  input  logic [ROB_TAG_W-1:0]       cdb_tag   [CDB_PORTS],
  input  rv_isa_pkg::word_t          cdb_v     [CDB_PORTS],

  input  logic                       rs_full,

  output logic                       alloc,
  output rv_isa_pkg::store_funct3_e  alloc_funct3,
  output rv_isa_pkg::word_t          alloc_imm,
  output logic [ROB_TAG_W-1:0]       alloc_rob_tag,
  output logic                       alloc_rs1_ready,
  output rv_isa_pkg::word_t          alloc_rs1_v,
  output logic [ROB_TAG_W-1:0]       alloc_rs1_tag,
  output logic                       alloc_rs2_ready,
  output rv_isa_pkg::word_t          alloc_rs2_v,
  output logic [ROB_TAG_W-1:0]       alloc_rs2_tag
);
  import rv_isa_pkg::*;

  // regfile first, then ROB, then a matching broadcast in this cycle
  function automatic void resolve_operand(
    input  logic                 rf_ready,
    input  word_t                rf_v,
    input  logic [ROB_TAG_W-1:0] tag,
    input  logic                 rob_ready,
    input  word_t                rob_v,
    output logic                 ready,
    output word_t                value
  );
    ready = 1'b0;
    value = '0;
    if (rf_ready) begin
      ready = 1'b1;
      value = rf_v;
    end else if (rob_ready) begin
      ready = 1'b1;
      value = rob_v;
    end else begin
      // lowest port wins if two buses carry the tag
      for (int p = CDB_PORTS - 1; p >= 0; p--) begin
        if (cdb_valid[p] && cdb_tag[p] == tag) begin
          ready = 1'b1;
          value = cdb_v[p];
        end
      end
    end
  endfunction

  always_comb begin
    resolve_operand(rs1_regfile_ready, rs1_regfile_v, rs1_regfile_tag,
                    rs1_rob_ready, rs1_rob_v, alloc_rs1_ready, alloc_rs1_v);
    resolve_operand(rs2_regfile_ready, rs2_regfile_v, rs2_regfile_tag,
                    rs2_rob_ready, rs2_rob_v, alloc_rs2_ready, alloc_rs2_v);
  end

  // a waiting operand keeps its producer tag for the snoop
  assign alloc_rs1_tag = rs1_regfile_tag;
  assign alloc_rs2_tag = rs2_regfile_tag;
  assign alloc_funct3  = issue_funct3;
  assign alloc_imm     = issue_imm;
  assign alloc_rob_tag = issue_rob_tag;

  // ack low means this request has not been taken yet
  assign alloc = issue_req && !issue_ack && !rs_full && !flush;

  always_ff @(posedge clk) begin
    if (reset) begin
      issue_ack <= 1'b0;
    end else if (alloc) begin
      issue_ack <= 1'b1;
    end else if (!issue_req) begin
      issue_ack <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- design/store_result_port.sv
`timescale 1ns/10ps
`default_nettype none

module store_result_port #(
  parameter int ROB_TAG_W = 3
) (
  input  logic                       clk,
  input  logic                       reset,

  input  logic                       pick,
  input  rv_isa_pkg::store_funct3_e  pick_funct3,
  input  rv_isa_pkg::word_t          pick_imm,
  input  rv_isa_pkg::word_t          pick_rs1_v,
  input  rv_isa_pkg::word_t          pick_rs2_v,
  input  logic [ROB_TAG_W-1:0]       pick_rob_tag,
  output logic                       out_busy,

  output logic                       res_req,
  input  logic                       res_ack,
  output logic [ROB_TAG_W-1:0]       res_rob_tag,
  output rv_isa_pkg::word_t          res_addr,
  output lsu_pkg::byte_mask_t        res_wmask,
  output rv_isa_pkg::word_t          res_wdata,

  output logic                       cdb_store_valid,
  output logic [ROB_TAG_W-1:0]       cdb_store_tag
);
  import rv_isa_pkg::*;
  import lsu_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_req,
    st_drain
  } state_e;

  state_e     state;
  word_t      addr;
  byte_off_t  offset;
  byte_mask_t wmask;
  word_t      wdata;

  // byte address and lane placement of the store data
  always_comb begin
    addr   = pick_rs1_v + pick_imm;
    offset = addr[1:0];
    wmask  = '0;
    wdata  = '0;
    case (pick_funct3)
      sb: begin
        wmask = byte_mask_t'(4'b0001 << offset);
        wdata = {24'b0, pick_rs2_v[7:0]} << {offset, 3'b000};
      end
      sh: begin
        // only half-word aligned offsets write anything
        if (!offset[0]) begin
          wmask = byte_mask_t'(4'b0011 << offset);
          wdata = {16'b0, pick_rs2_v[15:0]} << {offset, 3'b000};
        end
      end
      sw: begin
        wmask = '1;
        wdata = pick_rs2_v;
      end
      default: begin
        wmask = '0;
        wdata = '0;
      end
    endcase
  end

  // idle -> req until ack high -> drain until ack low
  always_ff @(posedge clk) begin
    if (reset) begin
      state           <= st_idle;
      cdb_store_valid <= 1'b0;
    end else begin
      cdb_store_valid <= pick;
      case (state)
        st_idle: begin
          if (pick) begin
            state <= st_req;
          end
        end
        st_req: begin
          if (res_ack) begin
            state <= st_drain;
          end
        end
        st_drain: begin
          if (!res_ack) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // held stable for the whole handshake
  always_ff @(posedge clk) begin
    if (pick) begin
      res_addr    <= addr;
      res_wmask   <= wmask;
      res_wdata   <= wdata;
      res_rob_tag <= pick_rob_tag;
    end
  end

  assign res_req       = (state == st_req);
  assign out_busy      = (state != st_idle);
  assign cdb_store_tag = res_rob_tag;

endmodule

`default_nettype wire

//--- design/store_rs.sv
`timescale 1ns/10ps
`default_nettype none

module store_rs #(
  parameter int ROB_TAG_W  = 3,
  parameter int RS_ENTRIES = 8,
  parameter int CDB_PORTS  = 3
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       flush,

  input  logic                       alloc,
  input  rv_isa_pkg::store_funct3_e  alloc_funct3,
  input  rv_isa_pkg::word_t          alloc_imm,
  input  logic [ROB_TAG_W-1:0]       alloc_rob_tag,
  input  logic                       alloc_rs1_ready,
  input  rv_isa_pkg::word_t          alloc_rs1_v,
  input  logic [ROB_TAG_W-1:0]       alloc_rs1_tag,
  input  logic                       alloc_rs2_ready,
  input  rv_isa_pkg::word_t          alloc_rs2_v,
  input  logic [ROB_TAG_W-1:0]       alloc_rs2_tag,
  output logic                       rs_full,

  input  logic                       cdb_valid [CDB_PORTS],
  input  logic [ROB_TAG_W-1:0]       cdb_tag   [CDB_PORTS],
  input  rv_isa_pkg::word_t          cdb_v     [CDB_PORTS],

  input  logic                       out_busy,
  output logic                       pick,
  output rv_isa_pkg::store_funct3_e  pick_funct3,
  output rv_isa_pkg::word_t          pick_imm,
  output rv_isa_pkg::word_t          pick_rs1_v,
  output rv_isa_pkg::word_t          pick_rs2_v,
  output logic [ROB_TAG_W-1:0]       pick_rob_tag
);
  import rv_isa_pkg::*;

  localparam int IDX_W = $clog2(RS_ENTRIES);

  // per-entry state
  logic                 busy      [RS_ENTRIES];
  store_funct3_e        funct3_q  [RS_ENTRIES];
  word_t                imm_q     [RS_ENTRIES];
  logic [ROB_TAG_W-1:0] rob_tag_q [RS_ENTRIES];
  logic                 rs1_ready [RS_ENTRIES];
  word_t                rs1_v     [RS_ENTRIES];
  logic [ROB_TAG_W-1:0] rs1_tag   [RS_ENTRIES];
  logic                 rs2_ready [RS_ENTRIES];
  word_t                rs2_v     [RS_ENTRIES];
  logic [ROB_TAG_W-1:0] rs2_tag   [RS_ENTRIES];

  logic [IDX_W-1:0] free_idx;
  logic [IDX_W-1:0] pick_idx;
  logic             pick_found;
  // entry after the last one picked
  logic [IDX_W-1:0] rr_ptr;

  function automatic logic snoop_hit(input logic [ROB_TAG_W-1:0] tag);
    logic hit;
    hit = 1'b0;
    for (int p = 0; p < CDB_PORTS; p++) begin
      if (cdb_valid[p] && cdb_tag[p] == tag) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // same lowest-port priority as the issue side
  function automatic word_t snoop_value(input logic [ROB_TAG_W-1:0] tag);
    word_t value;
    value = '0;
    for (int p = CDB_PORTS - 1; p >= 0; p--) begin
      if (cdb_valid[p] && cdb_tag[p] == tag) begin
        value = cdb_v[p];
      end
    end
    return value;
  endfunction

  // lowest free entry, full when none is left
  always_comb begin
    rs_full  = 1'b1;
    free_idx = '0;
    for (int i = RS_ENTRIES - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        rs_full  = 1'b0;
        free_idx = IDX_W'(i);
      end
    end
  end

  // round-robin scan for a store with both operands in
  always_comb begin
    logic [IDX_W-1:0] idx;
    pick_found = 1'b0;
    pick_idx   = '0;
    for (int i = 0; i < RS_ENTRIES; i++) begin
      idx = rr_ptr + IDX_W'(i);
      if (!pick_found && busy[idx] && rs1_ready[idx] && rs2_ready[idx]) begin
        pick_found = 1'b1;
        pick_idx   = idx;
      end
    end
  end

  assign pick         = pick_found && !out_busy && !flush;
  assign pick_funct3  = funct3_q[pick_idx];
  assign pick_imm     = imm_q[pick_idx];
  assign pick_rs1_v   = rs1_v[pick_idx];
  assign pick_rs2_v   = rs2_v[pick_idx];
  assign pick_rob_tag = rob_tag_q[pick_idx];

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      rr_ptr <= '0;
      for (int i = 0; i < RS_ENTRIES; i++) begin
        busy[i]      <= 1'b0;
        rs1_ready[i] <= 1'b0;
        rs2_ready[i] <= 1'b0;
      end
    end else begin
      for (int i = 0; i < RS_ENTRIES; i++) begin
        if (busy[i] && !rs1_ready[i] && snoop_hit(rs1_tag[i])) begin
          rs1_ready[i] <= 1'b1;
        end
        if (busy[i] && !rs2_ready[i] && snoop_hit(rs2_tag[i])) begin
          rs2_ready[i] <= 1'b1;
        end
      end
      // alloc only targets a free entry, pick only a busy one
      if (alloc) begin
        busy[free_idx]      <= 1'b1;
        rs1_ready[free_idx] <= alloc_rs1_ready;
        rs2_ready[free_idx] <= alloc_rs2_ready;
      end
      if (pick) begin
        busy[pick_idx] <= 1'b0;
        rr_ptr         <= pick_idx + 1'b1;
      end
    end
  end

  // operand values and instruction fields
  always_ff @(posedge clk) begin
    for (int i = 0; i < RS_ENTRIES; i++) begin
      if (busy[i] && !rs1_ready[i] && snoop_hit(rs1_tag[i])) begin
        rs1_v[i] <= snoop_value(rs1_tag[i]);
      end
      if (busy[i] && !rs2_ready[i] && snoop_hit(rs2_tag[i])) begin
        rs2_v[i] <= snoop_value(rs2_tag[i]);
      end
    end
    if (alloc) begin
      funct3_q[free_idx]  <= alloc_funct3;
      imm_q[free_idx]     <= alloc_imm;
      rob_tag_q[free_idx] <= alloc_rob_tag;
      rs1_v[free_idx]     <= alloc_rs1_v;
      rs1_tag[free_idx]   <= alloc_rs1_tag;
      rs2_v[free_idx]     <= alloc_rs2_v;
      rs2_tag[free_idx]   <= alloc_rs2_tag;
    end
  end

endmodule

`default_nettype wire

//--- design/store_unit_top.sv
`timescale 1ns/10ps
`default_nettype none

module store_unit_top #(
  parameter int ROB_TAG_W  = lsu_pkg::DEF_ROB_TAG_W,
  parameter int RS_ENTRIES = lsu_pkg::DEF_RS_ENTRIES,
  parameter int CDB_PORTS  = lsu_pkg::DEF_CDB_PORTS
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       flush,

  input  logic                       issue_req,
  output logic                       issue_ack,
  input  rv_isa_pkg::store_funct3_e  issue_funct3,
  input  rv_isa_pkg::word_t          issue_imm,
  input  logic [ROB_TAG_W-1:0]       issue_rob_tag,

  input  logic                       rs1_regfile_ready,
  input  rv_isa_pkg::word_t          rs1_regfile_v,
  input  logic [ROB_TAG_W-1:0]       rs1_regfile_tag,
  input  logic                       rs1_rob_ready,
  input  rv_isa_pkg::word_t          rs1_rob_v,
  input  logic                       rs2_regfile_ready,
  input  rv_isa_pkg::word_t          rs2_regfile_v,
  input  logic [ROB_TAG_W-1:0]       rs2_regfile_tag,
  input  logic                       rs2_rob_ready,
  input  rv_isa_pkg::word_t          rs2_rob_v,

  input  logic                       cdb_valid [CDB_PORTS],
  input  logic [ROB_TAG_W-1:0]       cdb_tag   [CDB_PORTS],
  input  rv_isa_pkg::word_t          cdb_v     [CDB_PORTS],

  output logic                       res_req,
  input  logic                       res_ack,
  output logic [ROB_TAG_W-1:0]       res_rob_tag,
  output rv_isa_pkg::word_t          res_addr,
  output lsu_pkg::byte_mask_t        res_wmask,
  output rv_isa_pkg::word_t          res_wdata,

  output logic                       cdb_store_valid,
  output logic [ROB_TAG_W-1:0]       cdb_store_tag
);
  import rv_isa_pkg::*;

  // issue side to station
  logic                 alloc;
  store_funct3_e        alloc_funct3;
  word_t                alloc_imm;
  logic [ROB_TAG_W-1:0] alloc_rob_tag;
  logic                 alloc_rs1_ready;
  word_t                alloc_rs1_v;
  logic [ROB_TAG_W-1:0] alloc_rs1_tag;
  logic                 alloc_rs2_ready;
  word_t                alloc_rs2_v;
  logic [ROB_TAG_W-1:0] alloc_rs2_tag;
  logic                 rs_full;

  // station to result side
  logic                 pick;
  store_funct3_e        pick_funct3;
  word_t                pick_imm;
  logic [ROB_TAG_W-1:0] pick_rob_tag;
  word_t                pick_rs1_v;
  word_t                pick_rs2_v;
  logic                 out_busy;

  store_issue_port #(
    .ROB_TAG_W(ROB_TAG_W),
    .CDB_PORTS(CDB_PORTS)
  ) i_store_issue_port (.*);

  store_rs #(
    .ROB_TAG_W (ROB_TAG_W),
    .RS_ENTRIES(RS_ENTRIES),
    .CDB_PORTS (CDB_PORTS)
  ) i_store_rs (.*);

  store_result_port #(
    .ROB_TAG_W(ROB_TAG_W)
  ) i_store_result_port (.*);

endmodule

`default_nettype wire

//--- files.f
design/rv_isa_pkg.sv
design/lsu_pkg.sv
design/store_issue_port.sv
design/store_rs.sv
design/store_result_port.sv
design/store_unit_top.sv
tb/store_unit_tb.sv

//--- tb/store_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

module store_unit_tb;
  import rv_isa_pkg::*;
  import lsu_pkg::*;

  localparam int ROB_TAG_W  = DEF_ROB_TAG_W;
  localparam int RS_ENTRIES = DEF_RS_ENTRIES;
  localparam int CDB_PORTS  = DEF_CDB_PORTS;
  localparam int NUM_TAGS   = 1 << ROB_TAG_W;
  localparam int CLK_PERIOD = 4;
  localparam int N_RANDOM   = 120;
  localparam int N_PRE_FLUSH = 5;
  localparam int N_AFTER    = 20;
  localparam int NUM_STORES = N_RANDOM + RS_ENTRIES + 3 + N_PRE_FLUSH + N_AFTER;

  typedef logic [ROB_TAG_W-1:0] tag_t;

  logic clk, reset, flush;
  logic issue_req, issue_ack;
  store_funct3_e issue_funct3;
  word_t issue_imm;
  tag_t issue_rob_tag;
  logic rs1_regfile_ready, rs1_rob_ready, rs2_regfile_ready, rs2_rob_ready;
  word_t rs1_regfile_v, rs1_rob_v, rs2_regfile_v, rs2_rob_v;
  tag_t rs1_regfile_tag, rs2_regfile_tag;
  logic cdb_valid [CDB_PORTS];
  tag_t cdb_tag [CDB_PORTS];
  word_t cdb_v [CDB_PORTS];
  logic res_req, res_ack, cdb_store_valid;
  tag_t res_rob_tag, cdb_store_tag;
  word_t res_addr, res_wdata;
  byte_mask_t res_wmask;

  // producers of operands, indexed by producer tag
  logic prod_out [NUM_TAGS];
  logic prod_done [NUM_TAGS];
  word_t prod_val [NUM_TAGS];
  // operand source chosen for the request being issued
  logic op_rf [2], op_dyn [2], op_rob_rdy [2];
  word_t op_rf_v [2], op_rob_v [2];
  tag_t op_tag [2];
  // expected results of pending stores, by store tag
  int pend_cnt [NUM_TAGS];
  word_t exp_addr [NUM_TAGS], exp_data [NUM_TAGS];
  byte_mask_t exp_mask [NUM_TAGS];
  logic [2:0] last_f3;
  word_t last_imm, last_v1, last_v2;
  tag_t last_tag;
  bit hold_ack, cdb_en;
  logic res_req_q;
  word_t held_addr, held_data;
  byte_mask_t held_mask;
  tag_t held_tag;

  store_unit_top #(
    .ROB_TAG_W (ROB_TAG_W),
    .RS_ENTRIES(RS_ENTRIES),
    .CDB_PORTS (CDB_PORTS)
  ) i_store_unit_top (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("ERR %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_mask(input string name, input byte_mask_t got, input byte_mask_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("ERR %s got 0x%01h expected 0x%01h", name, got, exp));
    end
  endtask

  task automatic check_tag(input string name, input tag_t got, input tag_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // lane placement written per byte lane
  function automatic void expect_store(input logic [2:0] f3, input word_t base, input word_t imm,
                                       input word_t src, output word_t addr,
                                       output byte_mask_t mask, output word_t data);
    int off;
    int shift;
    addr  = base + imm;
    off   = addr % 4;
    shift = (f3 == 3'd2) ? 0 : off;
    mask  = '0;
    data  = '0;
    for (int lane = 0; lane < 4; lane++) begin
      if ((f3 == 3'd0 && lane == off) || f3 == 3'd2 ||
          (f3 == 3'd1 && off % 2 == 0 && (lane == off || lane == off + 1))) begin
        mask[lane] = 1'b1;
        data[lane*8 +: 8] = src[(lane - shift)*8 +: 8];
      end
    end
  endfunction

  function automatic int count_pending();
    int n;
    n = 0;
    for (int t = 0; t < NUM_TAGS; t++) n += pend_cnt[t];
    return n;
  endfunction

  function automatic int find_tag(input logic want_out);
    int start;
    int c;
    start = $urandom % NUM_TAGS;
    for (int i = 0; i < NUM_TAGS; i++) begin
      c = (start + i) % NUM_TAGS;
      if (prod_out[c] == want_out) return c;
    end
    return -1;
  endfunction

  task automatic pick_operand(input int n, output word_t val);
    int src;
    int t;
    src = $urandom % 4;
    op_rf[n] = 1'b0;
    op_dyn[n] = 1'b0;
    op_rob_rdy[n] = 1'b0;
    op_rf_v[n] = $urandom;
    op_rob_v[n] = $urandom;
    op_tag[n] = $urandom;
    if (src == 0) begin
      // regfile wins over a stale rob value
      op_rf[n] = 1'b1;
      op_rob_rdy[n] = $urandom % 2;
      val = op_rf_v[n];
    end else if (src == 1) begin
      op_rob_rdy[n] = 1'b1;
      val = op_rob_v[n];
    end else begin
      op_dyn[n] = 1'b1;
      t = (src == 3) ? find_tag(1'b1) : -1;
      if (t < 0) begin
        t = find_tag(1'b0);
        if (t >= 0) begin
          prod_out[t] = 1'b1;
          prod_done[t] = 1'b0;
          prod_val[t] = $urandom;
        end
      end
      if (t < 0) t = find_tag(1'b1);
      op_tag[n] = t;
      val = prod_val[t];
    end
  endtask

  task automatic issue_store(input bit dup, input int stall_cycles);
    int start;
    int t;
    word_t a, d;
    byte_mask_t m;
    @(negedge clk);
    t = -1;
    if (dup) begin
      t = last_tag;
    end
    while (t < 0) begin
      start = $urandom % NUM_TAGS;
      for (int i = 0; i < NUM_TAGS; i++) begin
        if (t < 0 && pend_cnt[(start + i) % NUM_TAGS] == 0) t = (start + i) % NUM_TAGS;
      end
      if (t < 0) @(negedge clk);
    end
    if (dup) begin
      for (int n = 0; n < 2; n++) begin
        op_rf[n] = 1'b1;
        op_dyn[n] = 1'b0;
        op_rob_rdy[n] = 1'b0;
      end
      op_rf_v[0] = last_v1;
      op_rf_v[1] = last_v2;
    end else begin
      last_f3 = ($urandom % 16 < 13) ? 3'($urandom % 3) : 3'(3 + $urandom % 5);
      last_imm = $urandom;
      pick_operand(0, last_v1);
      pick_operand(1, last_v2);
      last_tag = t;
    end
    @(posedge clk);
    issue_req <= 1'b1;
    issue_funct3 <= store_funct3_e'(last_f3);
    issue_imm <= last_imm;
    issue_rob_tag <= tag_t'(t);
    rs1_regfile_ready <= op_rf[0];
    rs1_regfile_v <= op_rf_v[0];
    rs1_regfile_tag <= op_tag[0];
    rs2_regfile_ready <= op_rf[1];
    rs2_regfile_v <= op_rf_v[1];
    rs2_regfile_tag <= op_tag[1];
    if (stall_cycles > 0) begin
      repeat (stall_cycles) begin
        @(negedge clk);
        check_flag("issue_ack", issue_ack, 1'b0);
      end
      @(posedge clk);
      hold_ack = 1'b0;
    end
    do @(negedge clk); while (!issue_ack);
    expect_store(last_f3, last_v1, last_imm, last_v2, a, m, d);
    exp_addr[t] = a;
    exp_mask[t] = m;
    exp_data[t] = d;
    pend_cnt[t]++;
    @(posedge clk);
    issue_req <= 1'b0;
    do @(negedge clk); while (issue_ack);
  endtask

  // rob view and cdb broadcasts
  always @(posedge clk) begin : cdb_drive
    int t;
    rs1_rob_ready <= op_dyn[0] ? prod_done[op_tag[0]] : op_rob_rdy[0];
    rs1_rob_v <= (op_dyn[0] && prod_done[op_tag[0]]) ? prod_val[op_tag[0]] : op_rob_v[0];
    rs2_rob_ready <= op_dyn[1] ? prod_done[op_tag[1]] : op_rob_rdy[1];
    rs2_rob_v <= (op_dyn[1] && prod_done[op_tag[1]]) ? prod_val[op_tag[1]] : op_rob_v[1];
    for (int p = 0; p < CDB_PORTS; p++) begin
      cdb_valid[p] <= 1'b0;
      cdb_tag[p] <= $urandom;
      cdb_v[p] <= $urandom;
      t = find_tag(1'b1);
      if (cdb_en && !reset && t >= 0 && $urandom % 4 == 0) begin
        cdb_valid[p] <= 1'b1;
        cdb_tag[p] <= tag_t'(t);
        cdb_v[p] <= prod_val[t];
        prod_out[t] = 1'b0;
        prod_done[t] = 1'b1;
      end
    end
  end

  // store buffer with random ack delay
  initial begin : store_buffer
    int delay;
    forever begin
      @(negedge clk);
      if (res_req && !hold_ack) begin
        delay = $urandom % 7;
        repeat (delay) @(negedge clk);
        @(posedge clk);
        res_ack <= 1'b1;
        do @(negedge clk); while (res_req);
        @(posedge clk);
        res_ack <= 1'b0;
      end
    end
  end

  // result link and completion report
  always @(negedge clk) begin
    if (!reset) begin
      if (res_req && !res_req_q) begin
        check_flag("cdb_store_valid", cdb_store_valid, 1'b1);
        check_tag("cdb_store_tag", cdb_store_tag, res_rob_tag);
        if (pend_cnt[res_rob_tag] == 0) begin
          stop_on_error($sformatf("result for tag %0d that is not pending", res_rob_tag));
        end
        check_word("res_addr", res_addr, exp_addr[res_rob_tag]);
        check_mask("res_wmask", res_wmask, exp_mask[res_rob_tag]);
        check_word("res_wdata", res_wdata, exp_data[res_rob_tag]);
        pend_cnt[res_rob_tag]--;
      end else begin
        check_flag("cdb_store_valid", cdb_store_valid, 1'b0);
        if (res_req) begin
          check_tag("res_rob_tag", res_rob_tag, held_tag);
          check_word("res_addr", res_addr, held_addr);
          check_mask("res_wmask", res_wmask, held_mask);
          check_word("res_wdata", res_wdata, held_data);
        end else if (res_req_q) begin
          // request drops only once the store buffer has acked
          check_flag("res_ack", res_ack, 1'b1);
        end
      end
      // flushed stores never reach the result link
      if (flush) begin
        for (int t = 0; t < NUM_TAGS; t++) pend_cnt[t] = 0;
      end
    end
    res_req_q = res_req;
    held_tag = res_rob_tag;
    held_addr = res_addr;
    held_mask = res_wmask;
    held_data = res_wdata;
  end

  initial begin
    #(NUM_STORES * 200 * CLK_PERIOD);
    $display("timeout: the stores did not all complete in time");
    $display("Test FAILED");
    $fatal(1);
  end

  initial begin
    void'($urandom(74866));
    reset = 1'b1;
    flush = 1'b0;
    issue_req = 1'b0;
    issue_funct3 = sb;
    issue_imm = '0;
    issue_rob_tag = '0;
    rs1_regfile_ready = 1'b0;
    rs1_regfile_v = '0;
    rs1_regfile_tag = '0;
    rs2_regfile_ready = 1'b0;
    rs2_regfile_v = '0;
    rs2_regfile_tag = '0;
    rs1_rob_ready = 1'b0;
    rs1_rob_v = '0;
    rs2_rob_ready = 1'b0;
    rs2_rob_v = '0;
    res_ack = 1'b0;
    for (int p = 0; p < CDB_PORTS; p++) begin
      cdb_valid[p] = 1'b0;
      cdb_tag[p] = '0;
      cdb_v[p] = '0;
    end
    for (int t = 0; t < NUM_TAGS; t++) begin
      prod_out[t] = 1'b0;
      prod_done[t] = 1'b0;
      prod_val[t] = '0;
      pend_cnt[t] = 0;
    end
    for (int n = 0; n < 2; n++) begin
      op_rf[n] = 1'b0;
      op_dyn[n] = 1'b0;
      op_rob_rdy[n] = 1'b0;
      op_rf_v[n] = '0;
      op_rob_v[n] = '0;
      op_tag[n] = '0;
    end
    hold_ack = 1'b0;
    cdb_en = 1'b1;
    res_req_q = 1'b0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_flag("issue_ack", issue_ack, 1'b0);
    check_flag("res_req", res_req, 1'b0);
    check_flag("cdb_store_valid", cdb_store_valid, 1'b0);

    repeat (N_RANDOM) issue_store(1'b0, 0);

    // stall the store buffer until the station is full behind a held result
    @(posedge clk);
    hold_ack = 1'b1;
    do @(negedge clk); while (res_req || res_ack);
    @(posedge clk);
    while (!(count_pending() == RS_ENTRIES && res_req)) begin
      issue_store(1'b0, 0);
      @(posedge clk);
    end
    issue_store(1'b1, 30);
    do @(negedge clk); while (count_pending() != 0 || res_req || res_ack);

    // ready and waiting stores are dropped by a flush behind a held result
    hold_ack = 1'b1;
    cdb_en = 1'b0;
    issue_store(1'b1, 0);
    repeat (N_PRE_FLUSH) issue_store(1'b0, 0);
    repeat (3) @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    @(negedge clk);
    cdb_en = 1'b1;
    @(posedge clk);
    hold_ack = 1'b0;
    repeat (N_AFTER) issue_store(1'b0, 0);
    do @(negedge clk); while (count_pending() != 0 || res_req || res_ack);

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire
